/* vlog.f */
rtl/xbuf_pkg.sv
rtl/xbuf_port_if.sv
rtl/xbuf_clk_gate.sv
rtl/x_buffer_scm.sv
rtl/x_wb_loader.sv
rtl/x_feeder.sv
rtl/x_buffer_top.sv
test/x_buffer_properties.sv
test/tb_x_buffer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the X buffer simulation with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_x_buffer -o sim_tb_x_buffer

output="$(./obj_dir/sim_tb_x_buffer)"
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* test/tb_x_buffer.sv */
/*
 * X buffer testbench.
 * Loads rows over Wishbone from a table, runs feeds with and without
 * back-pressure and checks every beat against a row model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_x_buffer import xbuf_pkg::*;;

  localparam int unsigned WORD_SIZE = WORD_SIZE_DEF;
  localparam int unsigned WIDTH     = WIDTH_DEF;
  localparam int unsigned HEIGHT    = HEIGHT_DEF;
  localparam int unsigned N_OUTPUTS = N_OUTPUTS_DEF;
  localparam int WORD_W = $clog2(WIDTH);
  localparam int OUT_W  = $clog2(N_OUTPUTS);
  localparam int ROW_W  = 8 + WIDTH * WORD_SIZE;
  localparam int NUM_ROWS  = 10;
  localparam int NUM_FEEDS = 4;
  localparam int LIMIT = NUM_ROWS * 40 + NUM_FEEDS * HEIGHT * 200;
  localparam logic [7:0] CTRL_ADR   = 8'h80;  // Register bit 7, index 0.
  localparam logic [7:0] STATUS_ADR = 8'h81;

  typedef logic [ROW_W-1:0] row_t;  // {slot, output, word 1, word 0}.

  localparam row_t ROWS [NUM_ROWS] = '{
    {4'd0, 4'd0, 32'h1000_0001, 32'h1000_0000},
    {4'd0, 4'd1, 32'h1010_0001, 32'h1010_0000},
    {4'd1, 4'd0, 32'h1100_0001, 32'h1100_0000},
    {4'd1, 4'd1, 32'h1110_0001, 32'h1110_0000},
    {4'd2, 4'd0, 32'h1200_0001, 32'h1200_0000},
    {4'd2, 4'd1, 32'h1210_0001, 32'h1210_0000},
    {4'd3, 4'd0, 32'h1300_0001, 32'h1300_0000},
    {4'd3, 4'd1, 32'h1310_0001, 32'h1310_0000},
    {4'd2, 4'd1, 32'hBEEF_2101, 32'hBEEF_2100},  // Overwrites.
    {4'd0, 4'd0, 32'hCAFE_0001, 32'hCAFE_0000}
  };

  logic clk_i;
  logic rst_ni;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  logic [7:0] wb_adr_i;
  logic [WORD_SIZE-1:0] wb_dat_i;
  logic [WORD_SIZE-1:0] wb_dat_o;
  logic wb_ack_o;
  logic x_valid_o;
  logic x_ready_i;
  logic [N_OUTPUTS*WIDTH*WORD_SIZE-1:0] x_data_o;
  logic [$clog2(HEIGHT)-1:0] x_slot_o;

  logic [WIDTH-1:0][WORD_SIZE-1:0] model [HEIGHT][N_OUTPUTS];
  logic rand_ready = 1'b0;
  int beats = 0;
  int errors = 0;
  int checks = 0;

  x_buffer_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    void'($urandom(62));
    x_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      x_ready_i = rand_ready ? 1'($urandom % 2) : 1'b1;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic [7:0] data_adr(input int slot, input int out, input int word);
    return 8'((slot << (WORD_W + OUT_W)) | (out << WORD_W) | word);
  endfunction

  task automatic bus_access(input logic we, input logic [7:0] adr,
                            input logic [WORD_SIZE-1:0] wdat,
                            output logic [WORD_SIZE-1:0] rdat);
    int n;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    n = 0;
    do begin
      @(posedge clk_i);
      #1;
      n++;
    end while (!wb_ack_o && n < 16);
    if (!wb_ack_o) begin
      errors++;
      $display("No ack within 16 cycles for bus access to address 0x%0h", adr);
    end
    rdat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [WORD_SIZE-1:0] dat);
    logic [WORD_SIZE-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [7:0] adr, output logic [WORD_SIZE-1:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic apply_rows(input int first, input int last);
    row_t r;
    int s;
    int o;
    logic [WIDTH-1:0][WORD_SIZE-1:0] words;
    for (int i = first; i <= last; i++) begin
      r = ROWS[i];
      s = int'(r[ROW_W-1 -: 4]);
      o = int'(r[ROW_W-5 -: 4]);
      words = r[WIDTH*WORD_SIZE-1:0];
      for (int w = 0; w < WIDTH; w++) begin
        bus_write(data_adr(s, o, w), words[w]);
      end
      model[s][o] = words;
    end
  endtask

  task automatic run_feed(input bit restart);
    logic [WORD_SIZE-1:0] rd;
    int n;
    beats = 0;
    bus_write(CTRL_ADR, 32'h1);
    if (restart) begin
      bus_read(STATUS_ADR, rd);
      check("status busy", rd, 1);
      bus_write(CTRL_ADR, 32'h1);  // Ignored while busy.
    end
    n = 0;
    while (beats < HEIGHT && n < HEIGHT * 100) begin
      @(posedge clk_i);
      n++;
    end
    if (beats < HEIGHT) begin
      errors++;
      $display("Feed delivered only %0d of %0d beats", beats, HEIGHT);
    end
    bus_read(STATUS_ADR, rd);
    check("status busy", rd, 0);
    repeat (10) @(posedge clk_i);
    check("beat count", beats, HEIGHT);
  endtask

  // Beat completes at the next rising edge.
  always @(negedge clk_i) begin
    if (rst_ni && x_valid_o && x_ready_i) begin
      if (beats >= HEIGHT) begin
        errors++;
        $display("Unexpected extra beat for slot %0d", x_slot_o);
      end else begin
        check("x_slot_o", x_slot_o, beats);
        for (int o = 0; o < N_OUTPUTS; o++) begin
          for (int w = 0; w < WIDTH; w++) begin
            check($sformatf("x_data_o[%0d][%0d]", o, w),
                  x_data_o[(o * WIDTH + w) * WORD_SIZE +: WORD_SIZE], model[beats][o][w]);
          end
        end
      end
      beats++;
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk_i);
    $display("Timeout after %0d cycles, the run did not finish", LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [WORD_SIZE-1:0] rd;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b1;  // Start request held through reset.
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = CTRL_ADR;
    wb_dat_i = 32'h1;
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check("wb_ack_o", wb_ack_o, 0);
      check("x_valid_o", x_valid_o, 0);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    check("wb_ack_o", wb_ack_o, 0);
    check("x_valid_o", x_valid_o, 0);
    bus_read(data_adr(0, 0, 0), rd);
    check("wb_dat_o", rd, 0);

    apply_rows(0, 7);
    bus_read(data_adr(2, 1, 1), rd);
    check("wb_dat_o", rd, 0);
    run_feed(1'b1);

    rand_ready = 1'b1;  // Same beats under back-pressure.
    run_feed(1'b0);
    rand_ready = 1'b0;

    bus_write(data_adr(1, 0, 0), 32'hDEAD_BEEF);  // Unfinished row.
    run_feed(1'b0);

    apply_rows(8, 9);
    run_feed(1'b0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/x_buffer_properties.sv */
/*
 * X buffer bus and stream properties.
 * Ack timing, stream hold under back-pressure and quiet reset.
 */
`timescale 1ns/1ps
`default_nettype none

module x_buffer_properties #(
  parameter int unsigned DATA_W = 128,
  parameter int unsigned SLOT_W = 2
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              wb_cyc_i,
  input logic              wb_stb_i,
  input logic              wb_ack_o,
  input logic              x_valid_o,
  input logic              x_ready_i,
  input logic [DATA_W-1:0] x_data_o,
  input logic [SLOT_W-1:0] x_slot_o
);

  ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o without an active cycle");

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o longer than one cycle");

  stream_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_valid_o && !x_ready_i |=> x_valid_o && $stable(x_data_o) && $stable(x_slot_o))
    else $error("Beat changed while waiting for x_ready_i");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !wb_ack_o && !x_valid_o)
    else $error("wb_ack_o or x_valid_o high in reset");

endmodule

bind x_buffer_top x_buffer_properties #(
  .DATA_W ($bits(x_data_o)),
  .SLOT_W ($bits(x_slot_o))
) u_props (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_ack_o  (wb_ack_o),
  .x_valid_o (x_valid_o),
  .x_ready_i (x_ready_i),
  .x_data_o  (x_data_o),
  .x_slot_o  (x_slot_o)
);

`default_nettype wire

/* rtl/x_buffer_top.sv */
/*
 * X buffer subsystem top level.
 * Wishbone loader, latch-based X buffer and stream feeder.
 */
`timescale 1ns/1ps
`default_nettype none

module x_buffer_top import xbuf_pkg::*; #(
  parameter int unsigned WORD_SIZE = WORD_SIZE_DEF,
  parameter int unsigned WIDTH     = WIDTH_DEF,
  parameter int unsigned HEIGHT    = HEIGHT_DEF,
  parameter int unsigned N_OUTPUTS = N_OUTPUTS_DEF
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [WB_ADR_W-1:0]                  wb_adr_i,
  input  logic [WORD_SIZE-1:0]                 wb_dat_i,
  output logic [WORD_SIZE-1:0]                 wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 x_valid_o,
  input  logic                                 x_ready_i,
  output logic [N_OUTPUTS*WIDTH*WORD_SIZE-1:0] x_data_o,
  output logic [idx_w(HEIGHT)-1:0]             x_slot_o
);

  logic start;
  logic busy;

  xbuf_port_if #(
    .WORD_SIZE (WORD_SIZE),
    .WIDTH     (WIDTH),
    .HEIGHT    (HEIGHT),
    .N_OUTPUTS (N_OUTPUTS)
  ) port_if ();

  x_wb_loader #(
    .WORD_SIZE (WORD_SIZE),
    .WIDTH     (WIDTH),
    .HEIGHT    (HEIGHT),
    .N_OUTPUTS (N_OUTPUTS)
  ) u_loader (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .busy_i   (busy),
    .start_o  (start),
    .port     (port_if.ctrl)  // Write side only.
  );

  x_buffer_scm #(
    .WORD_SIZE (WORD_SIZE),
    .WIDTH     (WIDTH),
    .HEIGHT    (HEIGHT),
    .N_OUTPUTS (N_OUTPUTS)
  ) u_scm (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .port   (port_if.mem)
  );

  x_feeder #(
    .WORD_SIZE (WORD_SIZE),
    .WIDTH     (WIDTH),
    .HEIGHT    (HEIGHT),
    .N_OUTPUTS (N_OUTPUTS)
  ) u_feeder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start),
    .busy_o    (busy),
    .port      (port_if.ctrl),  // Read side only.
    .x_valid_o (x_valid_o),
    .x_ready_i (x_ready_i),
    .x_data_o  (x_data_o),
    .x_slot_o  (x_slot_o)
  );

endmodule

`default_nettype wire

/* rtl/x_feeder.sv */
/*
 * X buffer feeder.
 * Walks the slots in order, loads the read address of every output,
 * then presents the whole slot as one beat on a valid/ready stream.
 */
`timescale 1ns/1ps
`default_nettype none

module x_feeder import xbuf_pkg::*; #(
  parameter int unsigned WORD_SIZE = WORD_SIZE_DEF,
  parameter int unsigned WIDTH     = WIDTH_DEF,
  parameter int unsigned HEIGHT    = HEIGHT_DEF,
  parameter int unsigned N_OUTPUTS = N_OUTPUTS_DEF
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   start_i,
  output logic                                   busy_o,
  xbuf_port_if.ctrl                              port,
  output logic                                   x_valid_o,
  input  logic                                   x_ready_i,
  output logic [N_OUTPUTS*WIDTH*WORD_SIZE-1:0]   x_data_o,
  output logic [idx_w(HEIGHT)-1:0]               x_slot_o
);

  localparam int unsigned OUT_W  = idx_w(N_OUTPUTS);
  localparam int unsigned SLOT_W = idx_w(HEIGHT);

  localparam logic [OUT_W-1:0]  OUT_LAST  = OUT_W'(N_OUTPUTS - 1);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(HEIGHT - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_PRESENT
  } state_e;

  state_e            state_q;
  logic [SLOT_W-1:0] slot_q;
  logic [OUT_W-1:0]  out_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      slot_q  <= '0;
      out_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_ADDR;
            slot_q  <= '0;
            out_q   <= '0;
          end
        end
        ST_ADDR: begin
          if (out_q == OUT_LAST) begin
            out_q   <= '0;
            state_q <= ST_PRESENT;
          end else begin
            out_q <= out_q + 1'b1;  // One output per cycle.
          end
        end
        ST_PRESENT: begin
          if (x_ready_i) begin
            if (slot_q == SLOT_LAST) begin
              state_q <= ST_IDLE;
            end else begin
              slot_q  <= slot_q + 1'b1;
              state_q <= ST_ADDR;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != ST_IDLE);

  assign port.read_en   = (state_q == ST_ADDR);
  assign port.read_addr = {slot_q, out_q};

  assign x_valid_o = (state_q == ST_PRESENT);
  assign x_data_o  = port.rdata;  // No reads are issued while a beat waits.
  assign x_slot_o  = slot_q;

endmodule

`default_nettype wire

/* rtl/x_wb_loader.sv */
/*
 * X buffer Wishbone loader.
 * Classic slave that gathers bus words into one row per output and
 * commits a row to the SCM on the write of its last word. Also holds
 * the CTRL and STATUS registers.
 */
`timescale 1ns/1ps
`default_nettype none

module x_wb_loader import xbuf_pkg::*; #(
  parameter int unsigned WORD_SIZE = WORD_SIZE_DEF,
  parameter int unsigned WIDTH     = WIDTH_DEF,
  parameter int unsigned HEIGHT    = HEIGHT_DEF,
  parameter int unsigned N_OUTPUTS = N_OUTPUTS_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [WB_ADR_W-1:0]  wb_adr_i,
  input  logic [WORD_SIZE-1:0] wb_dat_i,
  output logic [WORD_SIZE-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 busy_i,
  output logic                 start_o,
  xbuf_port_if.ctrl            port
);

  localparam int unsigned WORD_W = idx_w(WIDTH);
  localparam int unsigned OUT_W  = idx_w(N_OUTPUTS);
  localparam int unsigned SLOT_W = idx_w(HEIGHT);
  localparam int unsigned ADDR_W = scm_addr_w(N_OUTPUTS, HEIGHT);

  logic                 req;
  logic                 is_reg;
  logic [WORD_W-1:0]    word_idx;
  logic [OUT_W-1:0]     out_idx;
  logic [SLOT_W-1:0]    slot_idx;
  logic [REG_IDX_W-1:0] reg_idx;
  logic                 data_wr;
  logic                 row_done;
  logic                 ctrl_wr;
  logic [WORD_SIZE-1:0] rd_word;

  logic [N_OUTPUTS-1:0][WIDTH-1:0][WORD_SIZE-1:0] row_q;

  logic                 ack_q;
  logic                 write_en_q;
  logic                 start_q;
  logic [ADDR_W-1:0]    write_addr_q;
  logic [WORD_SIZE-1:0] dat_q;

  // No new request is taken in the ack cycle.
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  assign is_reg   = wb_adr_i[REG_SEL_BIT];
  assign word_idx = wb_adr_i[WORD_W-1:0];
  assign out_idx  = wb_adr_i[WORD_W +: OUT_W];
  assign slot_idx = wb_adr_i[WORD_W+OUT_W +: SLOT_W];
  assign reg_idx  = wb_adr_i[REG_IDX_W-1:0];

  assign data_wr  = req & wb_we_i & ~is_reg;
  assign row_done = (word_idx == WORD_W'(WIDTH - 1));
  assign ctrl_wr  = req & wb_we_i & is_reg & (reg_idx == REG_CTRL);

  always_comb begin
    rd_word = '0;
    if (is_reg && reg_idx == REG_STATUS) begin
      rd_word[STATUS_BUSY_BIT] = busy_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_wr) begin
      row_q[out_idx][word_idx] <= wb_dat_i;  // Assembly only.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      write_en_q   <= 1'b0;
      start_q      <= 1'b0;
      write_addr_q <= '0;
      dat_q        <= '0;
    end else begin
      ack_q      <= req;
      write_en_q <= data_wr & row_done;
      start_q    <= ctrl_wr & wb_dat_i[CTRL_START_BIT];
      if (data_wr && row_done) begin
        write_addr_q <= {slot_idx, out_idx};
      end
      if (req) begin
        dat_q <= rd_word;
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;
  assign start_o  = start_q;

  assign port.write_en   = write_en_q;
  assign port.write_addr = write_addr_q;
  assign port.wdata      = row_q[write_addr_q[OUT_W-1:0]];  // Row including its last word.

endmodule

`default_nettype wire

/* rtl/x_buffer_scm.sv */
/*
 * X buffer standard-cell memory.
 * Latch array of HEIGHT slots by N_OUTPUTS rows, each entry written
 * through its own clock gate from a registered copy of the write data.
 * Every output keeps a registered slot address for its read port.
 */
`timescale 1ns/1ps
`default_nettype none

module x_buffer_scm import xbuf_pkg::*; #(
  parameter int unsigned WORD_SIZE = WORD_SIZE_DEF,
  parameter int unsigned WIDTH     = WIDTH_DEF,
  parameter int unsigned HEIGHT    = HEIGHT_DEF,
  parameter int unsigned N_OUTPUTS = N_OUTPUTS_DEF
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  xbuf_port_if.mem     port
);

  localparam int unsigned OUT_W  = idx_w(N_OUTPUTS);
  localparam int unsigned SLOT_W = idx_w(HEIGHT);

  logic [WIDTH-1:0][WORD_SIZE-1:0]  wdata_q;
  logic [N_OUTPUTS-1:0][SLOT_W-1:0] read_addr_q;
  logic [HEIGHT-1:0][N_OUTPUTS-1:0] clk_w;

  logic [WIDTH-1:0][WORD_SIZE-1:0]  column [N_OUTPUTS][HEIGHT];

  always_ff @(posedge clk_i) begin
    if (port.write_en) begin
      wdata_q <= port.wdata;  // Held for the gated pulse.
    end
  end

  for (genvar o = 0; o < N_OUTPUTS; o++) begin : gen_read_port
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        read_addr_q[o] <= '0;
      end else if (port.read_en && port.read_addr[OUT_W-1:0] == OUT_W'(o)) begin
        read_addr_q[o] <= port.read_addr[OUT_W +: SLOT_W];
      end
    end

    assign port.rdata[o] = column[o][read_addr_q[o]];
  end

  for (genvar h = 0; h < HEIGHT; h++) begin : gen_slot
    for (genvar o = 0; o < N_OUTPUTS; o++) begin : gen_entry
      logic [WIDTH-1:0][WORD_SIZE-1:0] entry_q;

      xbuf_clk_gate u_cg (
        .clk_i     (clk_i),
        .en_i      (port.write_en &&
                    port.write_addr[OUT_W-1:0] == OUT_W'(o) &&
                    port.write_addr[OUT_W +: SLOT_W] == SLOT_W'(h)),
        .test_en_i (1'b0),  // No scan.
        .clk_o     (clk_w[h][o])
      );

      always_latch begin
        if (clk_w[h][o]) begin
          entry_q <= wdata_q;
        end
      end

      assign column[o][h] = entry_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/xbuf_clk_gate.sv */
/*
 * Clock gate.
 * Latch-based enable capture during the low phase, ANDed with the
 * clock so the gated output cannot glitch.
 */
`timescale 1ns/1ps
`default_nettype none

module xbuf_clk_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latch;

  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | test_en_i;  // Transparent while clock is low.
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

`default_nettype wire

/* rtl/xbuf_port_if.sv */
/*
 * X buffer port bundle.
 * Carries the SCM write port and the SCM read port between the
 * loader, the feeder and the latch array.
 */
`timescale 1ns/1ps
`default_nettype none

interface xbuf_port_if import xbuf_pkg::*; #(
  parameter int unsigned WORD_SIZE = WORD_SIZE_DEF,
  parameter int unsigned WIDTH     = WIDTH_DEF,
  parameter int unsigned HEIGHT    = HEIGHT_DEF,
  parameter int unsigned N_OUTPUTS = N_OUTPUTS_DEF
) ();

  logic                                           write_en;
  logic [scm_addr_w(N_OUTPUTS, HEIGHT)-1:0]       write_addr;
  logic [WIDTH-1:0][WORD_SIZE-1:0]                wdata;
  logic                                           read_en;
  logic [scm_addr_w(N_OUTPUTS, HEIGHT)-1:0]       read_addr;
  logic [N_OUTPUTS-1:0][WIDTH-1:0][WORD_SIZE-1:0] rdata;

  modport ctrl (
    output write_en, write_addr, wdata, read_en, read_addr,
    input  rdata
  );

  modport mem (
    input  write_en, write_addr, wdata, read_en, read_addr,
    output rdata
  );

endinterface

`default_nettype wire

/* rtl/xbuf_pkg.sv */
/*
 * X buffer package.
 * Default buffer geometry, the Wishbone register map and the
 * helpers that derive index and SCM address widths.
 */
`default_nettype none

package xbuf_pkg;

  localparam int unsigned WORD_SIZE_DEF = 32;
  localparam int unsigned WIDTH_DEF     = 2;
  localparam int unsigned HEIGHT_DEF    = 4;
  localparam int unsigned N_OUTPUTS_DEF = 2;

  localparam int unsigned WB_ADR_W    = 8;
  localparam int unsigned REG_SEL_BIT = 7;  // High for register accesses.
  localparam int unsigned REG_IDX_W   = REG_SEL_BIT;

  localparam logic [REG_IDX_W-1:0] REG_CTRL   = 'd0;
  localparam logic [REG_IDX_W-1:0] REG_STATUS = 'd1;

  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned STATUS_BUSY_BIT = 0;

  // Index width for n entries with a floor of one bit.
  function automatic int unsigned idx_w(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic int unsigned scm_addr_w(input int unsigned n_outputs,
                                             input int unsigned height);
    return idx_w(n_outputs) + idx_w(height);  // Output bits below the slot bits.
  endfunction

endpackage

`default_nettype wire
